// File: include/scan_settings.svh
`ifndef SCAN_SETTINGS_SVH
`define SCAN_SETTINGS_SVH

// Width of one fill-level word.
// Eight bits cover the range from empty up to a full buffer.
`define SCAN_MEM_W 8

// Amount the fill level changes on every clock while scanning or draining.
// One step stands for ten percent of the buffer.
`define SCAN_MEM_STEP 10

// Fill level of a full buffer.
// A scanner stops here and asks the collector for a flush.
`define SCAN_MEM_FULL 100

// Fill level at which a scanning unit tells its peer to leave low power.
// The peer then has half a scan to get ready in standby.
`define SCAN_WAKE_LEVEL 50

`endif

// File: rtl/scan_pkg.sv
package scan_pkg;

	// Operating state of one scanner unit.
	// The codes are also what the state display shows, so they stay fixed.
	//
	// A unit walks through the states in a ring.
	// It sleeps in low_power until its peer or the empty-peer rule wakes it.
	// In standby it waits for the go-ahead to start filling the buffer.
	// While scanning the fill level climbs by one step per clock.
	// In idle the buffer is full and the unit waits for the collector.
	// During transfer the buffer drains one step per clock back to empty.
	typedef enum logic [2:0] {
		// Asleep with an empty buffer.
		low_power = 3'd0,
		// Awake and empty, waiting to be told to scan.
		standby   = 3'd1,
		// Filling the buffer.
		scanning  = 3'd2,
		// Full and holding until the collector acknowledges.
		idle      = 3'd3,
		// Draining the buffer to the collector.
		transfer  = 3'd4
	} scan_state_t;

	// Codes 5 to 7 are never entered.
	// A unit that somehow lands there falls back to low_power.

endpackage

// File: rtl/scanner_unit.sv
`timescale 1ns/1ns
`include "scan_settings.svh"

module scanner_unit #(
	// Set to 1 for the primary unit and 0 for the alternate.
	parameter bit PRIMARY = 1'b1
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    flush,
	input  logic                    start_scan_in,
	input  logic                    goto_stby_in,
	input  logic [`SCAN_MEM_W-1:0]  alt_mem_used,
	output logic                    rdy_flush,
	output logic                    start_scan_out,
	output logic                    goto_stby_out,
	output logic [`SCAN_MEM_W-1:0]  mem_used,
	output scan_pkg::scan_state_t   state
);

	import scan_pkg::*;

	// Sized copies of the settings so that the fill arithmetic stays at word width.
	localparam logic [`SCAN_MEM_W-1:0] mem_step   = `SCAN_MEM_STEP;
	localparam logic [`SCAN_MEM_W-1:0] mem_full   = `SCAN_MEM_FULL;
	localparam logic [`SCAN_MEM_W-1:0] wake_level = `SCAN_WAKE_LEVEL;

	// High when this is the primary and the peer buffer is empty.
	// The alternate never sees this term, so it only moves on peer signals.
	logic alt_empty;

	// Combined conditions for leaving low_power and standby.
	logic wake;
	logic start;

	// Next values of the state register and the fill counter.
	scan_state_t                state_next;
	logic [`SCAN_MEM_W-1:0]     mem_next;

	assign alt_empty = PRIMARY && (alt_mem_used == '0);

	// The primary restarts the pair on its own when the alternate is empty.
	// Without that rule neither unit would ever leave low_power after reset.
	assign wake  = goto_stby_in || alt_empty;
	assign start = start_scan_in || alt_empty;

	// State and fill update.
	always_comb begin
		state_next = state;
		mem_next   = mem_used;
		case (state)
			low_power: begin
				if (wake) begin
					state_next = standby;
				end
			end
			standby: begin
				// The buffer is already empty here.
				// Clearing it again keeps the start of a scan exact.
				if (start) begin
					state_next = scanning;
					mem_next   = '0;
				end
			end
			scanning: begin
				mem_next = mem_used + mem_step;
				// The edge that fills the buffer also stops the scan.
				if (mem_next == mem_full) begin
					state_next = idle;
				end
			end
			idle: begin
				// The collector acknowledges by raising flush.
				if (flush) begin
					state_next = transfer;
				end
			end
			transfer: begin
				mem_next = mem_used - mem_step;
				if (mem_next == '0) begin
					state_next = low_power;
				end
			end
			default: begin
				state_next = low_power;
				mem_next   = '0;
			end
		endcase
	end

	// State register and fill counter.
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= low_power;
			mem_used <= '0;
		end else begin
			state    <= state_next;
			mem_used <= mem_next;
		end
	end

	// Flush request of the four-phase handshake.
	// It drops once the unit has moved on to transfer.
	assign rdy_flush = (state == idle);

	// A full unit hands the scanning over to its peer.
	assign start_scan_out = (state == idle);

	// Halfway through a scan the peer is woken so that it is ready in time.
	assign goto_stby_out = (state == scanning) && (mem_used >= wake_level);

	// The counter stops at full and never runs past it.
	a_fill_max: assert property (
		@(posedge clk) disable iff (rst)
		mem_used <= mem_full
	);

	// The fill only ever moves in whole steps.
	a_fill_step: assert property (
		@(posedge clk) disable iff (rst)
		(mem_used % mem_step) == '0
	);

	// A sleeping or waiting unit holds no data.
	a_fill_empty: assert property (
		@(posedge clk) disable iff (rst)
		(state == low_power || state == standby) |-> (mem_used == '0)
	);

endmodule

// File: rtl/scan_display.sv
`timescale 1ns/1ns
`include "scan_settings.svh"

module scan_display (
	input  scan_pkg::scan_state_t   state,
	input  logic [`SCAN_MEM_W-1:0]  mem_used,
	output logic [6:0]              hex_state,
	output logic [6:0]              hex_count
);

	localparam logic [`SCAN_MEM_W-1:0] mem_step = `SCAN_MEM_STEP;

	// Digit shown for the state and for the fill in tens.
	logic [3:0] state_digit;
	logic [3:0] count_digit;

	// Active-low segment pattern of one hex digit.
	// Bit order is g f e d c b a, so a zero lights the segment.
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		case (digit)
			4'h0: seg7 = 7'b1000000;
			4'h1: seg7 = 7'b1111001;
			4'h2: seg7 = 7'b0100100;
			4'h3: seg7 = 7'b0110000;
			4'h4: seg7 = 7'b0011001;
			4'h5: seg7 = 7'b0010010;
			4'h6: seg7 = 7'b0000010;
			4'h7: seg7 = 7'b1111000;
			4'h8: seg7 = 7'b0000000;
			4'h9: seg7 = 7'b0010000;
			4'ha: seg7 = 7'b0001000;
			4'hb: seg7 = 7'b0000011;
			4'hc: seg7 = 7'b1000110;
			4'hd: seg7 = 7'b0100001;
			4'he: seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	// The state code is shown as it is, 0 for low power up to 4 for transfer.
	assign state_digit = {1'b0, state};

	// Each step is ten percent, so the fill divided by the step is the tens digit.
	// A full buffer gives ten and shows as A.
	assign count_digit = 4'(mem_used / mem_step);

	// Both digits use the same table and follow the registered inputs directly.
	assign hex_state = seg7(state_digit);
	assign hex_count = seg7(count_digit);

endmodule

// File: rtl/control_scanner.sv
`timescale 1ns/1ns
`include "scan_settings.svh"

module control_scanner (
	input  logic       clk,
	input  logic       rst,
	input  logic       flush,
	output logic       rdy_flush,
	output logic [6:0] hex_state_s1,
	output logic [6:0] hex_count_s1,
	output logic [6:0] hex_state_s2,
	output logic [6:0] hex_count_s2
);

	import scan_pkg::*;

	// Fill level and state of the primary (s1) and the alternate (s2).
	logic [`SCAN_MEM_W-1:0] mem_used_s1;
	logic [`SCAN_MEM_W-1:0] mem_used_s2;
	scan_state_t            state_s1;
	scan_state_t            state_s2;

	// Peer signals leaving each unit.
	// Each one is wired into the matching input of the other unit.
	logic start_scan_1;
	logic start_scan_2;
	logic goto_stby_1;
	logic goto_stby_2;

	// Flush requests of the two units.
	logic rdy_flush_1;
	logic rdy_flush_2;

	// Primary unit. It carries the rule that restarts the pair.
	scanner_unit #(.PRIMARY(1'b1)) ps_i (
		.clk            (clk),
		.rst            (rst),
		.flush          (flush),
		.start_scan_in  (start_scan_2),
		.goto_stby_in   (goto_stby_2),
		.alt_mem_used   (mem_used_s2),
		.rdy_flush      (rdy_flush_1),
		.start_scan_out (start_scan_1),
		.goto_stby_out  (goto_stby_1),
		.mem_used       (mem_used_s1),
		.state          (state_s1)
	);

	// Alternate unit. It only moves when the primary tells it to.
	scanner_unit #(.PRIMARY(1'b0)) as_i (
		.clk            (clk),
		.rst            (rst),
		.flush          (flush),
		.start_scan_in  (start_scan_1),
		.goto_stby_in   (goto_stby_1),
		.alt_mem_used   (mem_used_s1),
		.rdy_flush      (rdy_flush_2),
		.start_scan_out (start_scan_2),
		.goto_stby_out  (goto_stby_2),
		.mem_used       (mem_used_s2),
		.state          (state_s2)
	);

	// The collector sees one request.
	// A single acknowledge drains every unit that is idle at that moment.
	assign rdy_flush = rdy_flush_1 | rdy_flush_2;

	scan_display disp1_i (
		.state     (state_s1),
		.mem_used  (mem_used_s1),
		.hex_state (hex_state_s1),
		.hex_count (hex_count_s1)
	);

	scan_display disp2_i (
		.state     (state_s2),
		.mem_used  (mem_used_s2),
		.hex_state (hex_state_s2),
		.hex_count (hex_count_s2)
	);

	// The peer signalling hands the scan over, so two scans never overlap.
	a_one_scanning: assert property (
		@(posedge clk) disable iff (rst)
		!(state_s1 == scanning && state_s2 == scanning)
	);

endmodule

// File: test/control_scanner_tb.sv
`timescale 1ns/1ns
`include "scan_settings.svh"

module control_scanner_tb;

	import scan_pkg::*;

	localparam logic [`SCAN_MEM_W-1:0] step_v = `SCAN_MEM_STEP;
	localparam logic [`SCAN_MEM_W-1:0] full_v = `SCAN_MEM_FULL;
	localparam logic [`SCAN_MEM_W-1:0] wake_v = `SCAN_WAKE_LEVEL;

	// Active-low patterns in g..a order for digits 0 to A.
	// Entries past A are never shown, so they stay blank.
	localparam logic [6:0] seg_table [0:15] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h7f, 7'h7f, 7'h7f, 7'h7f, 7'h7f
	};

	// Each stimulus row gives the cycles between seeing rdy_flush and raising flush.
	// It also gives the number of handshakes in that row.
	// Delay 0 rows make the units alternate.
	// The delay 30 row lets both fill up.
	// The delay 10 row raises flush on the edge where the alternate just becomes full.
	localparam logic [2:0] num_rows = 3'd5;
	localparam logic [7:0] row_delay [0:4] = '{8'd0, 8'd30, 8'd10, 8'd3, 8'd0};
	localparam logic [7:0] row_count [0:4] = '{8'd4, 8'd1, 8'd1, 8'd2, 8'd3};

	logic       clk;
	logic       rst;
	logic       flush;
	logic       rdy_flush;
	logic [6:0] hex_state_s1;
	logic [6:0] hex_count_s1;
	logic [6:0] hex_state_s2;
	logic [6:0] hex_count_s2;

	// Reference model of the primary (1) and the alternate (2).
	scan_state_t            m_state_1;
	scan_state_t            m_state_2;
	logic [`SCAN_MEM_W-1:0] m_fill_1;
	logic [`SCAN_MEM_W-1:0] m_fill_2;

	logic [2:0] row;
	logic [7:0] hs;

	control_scanner dut_i (
		.clk          (clk),
		.rst          (rst),
		.flush        (flush),
		.rdy_flush    (rdy_flush),
		.hex_state_s1 (hex_state_s1),
		.hex_count_s1 (hex_count_s1),
		.hex_state_s2 (hex_state_s2),
		.hex_count_s2 (hex_count_s2)
	);

	always #20 clk = ~clk;

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_seg(input string name, input logic [6:0] expected,
			input logic [6:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %b got %b",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %b got %b",
				$time, name, expected, actual);
			abort_run();
		end
	endtask

	// Next state and fill of one unit, taken straight from the transition rules.
	// Only the primary may restart on an empty peer.
	function automatic void unit_next(input bit primary, input scan_state_t st,
			input logic [`SCAN_MEM_W-1:0] fill, input scan_state_t peer_st,
			input logic [`SCAN_MEM_W-1:0] peer_fill, output scan_state_t st_n,
			output logic [`SCAN_MEM_W-1:0] fill_n);
		logic peer_wakes;
		logic peer_full;
		logic restart;
		peer_wakes = (peer_st == scanning) && (peer_fill >= wake_v);
		peer_full  = (peer_st == idle);
		restart    = primary && (peer_fill == '0);
		st_n   = st;
		fill_n = fill;
		case (st)
			low_power: begin
				if (peer_wakes || restart) begin
					st_n = standby;
				end
			end
			standby: begin
				if (peer_full || restart) begin
					st_n   = scanning;
					fill_n = '0;
				end
			end
			scanning: begin
				fill_n = fill + step_v;
				if (fill_n == full_v) begin
					st_n = idle;
				end
			end
			idle: begin
				if (flush) begin
					st_n = transfer;
				end
			end
			default: begin
				fill_n = fill - step_v;
				if (fill_n == '0) begin
					st_n = low_power;
				end
			end
		endcase
	endfunction

	// Advances the model by one rising edge, both units from the same old values.
	task automatic model_edge();
		scan_state_t            st_1;
		scan_state_t            st_2;
		logic [`SCAN_MEM_W-1:0] fill_1;
		logic [`SCAN_MEM_W-1:0] fill_2;
		if (rst) begin
			st_1   = low_power;
			st_2   = low_power;
			fill_1 = '0;
			fill_2 = '0;
		end else begin
			unit_next(1'b1, m_state_1, m_fill_1, m_state_2, m_fill_2, st_1, fill_1);
			unit_next(1'b0, m_state_2, m_fill_2, m_state_1, m_fill_1, st_2, fill_2);
		end
		m_state_1 = st_1;
		m_state_2 = st_2;
		m_fill_1  = fill_1;
		m_fill_2  = fill_2;
	endtask

	task automatic compare_outputs();
		check_bit("rdy_flush", (m_state_1 == idle) || (m_state_2 == idle), rdy_flush);
		check_seg("hex_state_s1", seg_table[{1'b0, m_state_1}], hex_state_s1);
		check_seg("hex_count_s1", seg_table[4'(m_fill_1 / step_v)], hex_count_s1);
		check_seg("hex_state_s2", seg_table[{1'b0, m_state_2}], hex_state_s2);
		check_seg("hex_count_s2", seg_table[4'(m_fill_2 / step_v)], hex_count_s2);
	endtask

	// In one clock the model follows the rising edge and the outputs are compared
	// at the falling edge.
	// Callers drive inputs right after this returns, so they change on the falling edge.
	task automatic step_cycle();
		@(posedge clk);
		model_edge();
		@(negedge clk);
		compare_outputs();
	endtask

	task automatic wait_rdy(input logic level, input string what);
		int cycles;
		cycles = 0;
		while (rdy_flush !== level) begin
			if (cycles == 200) begin
				$display("TIMEOUT: waited 200 cycles for %s and it never came", what);
				abort_run();
			end
			step_cycle();
			cycles++;
		end
	endtask

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		flush     = 1'b0;
		m_state_1 = low_power;
		m_state_2 = low_power;
		m_fill_1  = '0;
		m_fill_2  = '0;
		repeat (5) step_cycle();
		rst = 1'b0;
		for (row = 3'd0; row < num_rows; row++) begin
			for (hs = 8'd0; hs < row_count[row]; hs++) begin
				wait_rdy(1'b1, "rdy_flush to rise");
				repeat (row_delay[row]) step_cycle();
				// After a long hold both buffers must be full and waiting.
				if (row_delay[row] >= 8'd20) begin
					check_seg("hex_state_s1 before flush", seg_table[4'h3], hex_state_s1);
					check_seg("hex_state_s2 before flush", seg_table[4'h3], hex_state_s2);
					check_seg("hex_count_s1 before flush", seg_table[4'ha], hex_count_s1);
					check_seg("hex_count_s2 before flush", seg_table[4'ha], hex_count_s2);
				end
				flush = 1'b1;
				wait_rdy(1'b0, "rdy_flush to fall after flush");
				flush = 1'b0;
			end
		end
		// A few more cycles show that the pair restarts after the last drain.
		repeat (6) step_cycle();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: control_scanner.f
+incdir+include
rtl/scan_pkg.sv
rtl/scanner_unit.sv
rtl/scan_display.sv
rtl/control_scanner.sv
test/control_scanner_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := control_scanner_tb
RTL_TOP    := control_scanner
FILELIST   := control_scanner.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run counts as passed only if the pass line shows up in the output.
run: build
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
